/* logic/mips_pkg.sv */
package mips_pkg;

    // Widths that carry a meaning
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;

    // Primary opcodes kept in this core
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_SLTIU = 6'h0B,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // Function field of R-type instructions
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A,
        FN_SLTU = 6'h2B
    } funct_t;

    typedef enum logic [1:0] {
        HALTED,
        FETCH,
        EXEC,
        MEM
    } cpu_state_t;

    // Fields and format flags pulled out of the instruction register
    typedef struct packed {
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        logic [4:0]  shamt;
        imm_t        imm;
        logic [25:0] index;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        is_jump_reg;
        logic        is_jump;
        logic        writes_reg;
        reg_idx_t    dest;
    } decoded_t;

    localparam word_t    RESET_VECTOR = 32'hBFC0_0000;
    localparam word_t    HALT_ADDR    = 32'h0000_0000;
    localparam reg_idx_t REG_V0       = 5'd2;
    localparam word_t    WORD_BYTES   = 32'd4;

endpackage

/* logic/mips_control.sv */
`timescale 1ns/1ps

module mips_control
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       waitrequest,
    input  decoded_t   decoded,
    input  word_t      next_pc,
    output cpu_state_t state,
    output logic       active,
    output logic       read,
    output logic       write,
    output logic       addr_sel,
    output logic       ir_load,
    output logic       pc_advance,
    output logic       reg_write
);

    cpu_state_t next_state;
    logic       mem_op;
    logic       halt_next;

    assign mem_op    = decoded.is_load || decoded.is_store;
    assign halt_next = (next_pc == HALT_ADDR);
    assign active    = (state != HALTED);

    always_comb begin
        next_state = state;
        read       = 1'b0;
        write      = 1'b0;
        addr_sel   = 1'b0;
        ir_load    = 1'b0;
        pc_advance = 1'b0;
        reg_write  = 1'b0;
        case (state)
            FETCH: begin
                // Read held until the slave accepts it
                read = 1'b1;
                if (!waitrequest) begin
                    ir_load    = 1'b1;
                    next_state = EXEC;
                end
            end
            EXEC: begin
                if (mem_op) begin
                    next_state = MEM;
                end else begin
                    reg_write  = decoded.writes_reg;
                    pc_advance = 1'b1;
                    next_state = halt_next ? HALTED : FETCH;
                end
            end
            MEM: begin
                // Data access uses the computed address
                addr_sel = 1'b1;
                read     = decoded.is_load;
                write    = decoded.is_store;
                if (!waitrequest) begin
                    reg_write  = decoded.is_load;
                    pc_advance = 1'b1;
                    next_state = halt_next ? HALTED : FETCH;
                end
            end
            HALTED: begin
                next_state = HALTED;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    // Bus is never driven both ways at once
    assert property (@(posedge clk) disable iff (reset) !(read && write));

    // Once halted the master stays off the bus
    assert property (@(posedge clk) disable iff (reset)
        (state == HALTED) |-> (!read && !write));

endmodule

/* logic/mips_pc.sv */
`timescale 1ns/1ps

module mips_pc
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     pc_advance,
    input  decoded_t decoded,
    input  logic     branch_taken,
    input  word_t    jump_target_reg,
    output word_t    pc,
    output word_t    next_pc
);

    word_t slot_addr;
    word_t branch_offset;
    word_t branch_target;
    word_t jump_target;
    word_t selected_target;
    word_t redirect_target;
    logic  redirect_pending;

    // Targets are relative to the delay-slot address
    assign slot_addr     = pc + WORD_BYTES;
    assign branch_offset = {{14{decoded.imm[15]}}, decoded.imm, 2'b00};
    assign branch_target = slot_addr + branch_offset;
    assign jump_target   = {slot_addr[31:28], decoded.index, 2'b00};

    always_comb begin
        if (decoded.is_jump_reg) begin
            selected_target = jump_target_reg;
        end else if (decoded.is_jump) begin
            selected_target = jump_target;
        end else begin
            selected_target = branch_target;
        end
    end

    // Delay slot finishes first, then the recorded target applies
    assign next_pc = redirect_pending ? redirect_target : slot_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc               <= RESET_VECTOR;
            redirect_pending <= 1'b0;
        end else if (pc_advance) begin
            pc               <= next_pc;
            redirect_pending <= branch_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (pc_advance && branch_taken) begin
            redirect_target <= selected_target;
        end
    end

    assert property (@(posedge clk) disable iff (reset) pc_advance |=> (pc[1:0] == 2'b00));

endmodule

/* logic/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    input  logic     write_en,
    input  reg_idx_t write_idx,
    input  word_t    write_data,
    output word_t    rs_data,
    output word_t    rt_data,
    output word_t    v0
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (write_idx != '0)) begin
            regs[write_idx] <= write_data;
        end
    end

    // $zero reads as zero whatever is stored
    assign rs_data = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_data = (rt_idx == '0) ? '0 : regs[rt_idx];
    assign v0      = regs[REG_V0];

    // Flags a nonzero result aimed at $zero
    assert property (@(posedge clk) disable iff (reset)
        (write_en && (write_data != '0)) |-> (write_idx != '0))
        else $warning("Nonzero write to register zero discarded");

endmodule

/* logic/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu
    import mips_pkg::*;
(
    input  word_t    instr,
    input  word_t    rs_data,
    input  word_t    rt_data,
    output decoded_t decoded,
    output word_t    alu_result,
    output word_t    mem_addr,
    output logic     branch_taken
);

    opcode_t opcode;
    funct_t  funct;
    logic    is_rtype;
    word_t   imm_sext;
    word_t   imm_zext;

    assign opcode   = opcode_t'(instr[31:26]);
    assign funct    = funct_t'(instr[5:0]);
    assign is_rtype = (opcode == OP_RTYPE);
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'h0000, instr[15:0]};

    always_comb begin
        decoded.rs          = instr[25:21];
        decoded.rt          = instr[20:16];
        decoded.rd          = instr[15:11];
        decoded.shamt       = instr[10:6];
        decoded.imm         = instr[15:0];
        decoded.index       = instr[25:0];
        decoded.is_load     = (opcode == OP_LW);
        decoded.is_store    = (opcode == OP_SW);
        decoded.is_branch   = (opcode == OP_BEQ) || (opcode == OP_BNE);
        decoded.is_jump     = (opcode == OP_J);
        decoded.is_jump_reg = is_rtype && (funct == FN_JR);
        // R-type writes rd, I-type writes rt
        decoded.dest        = is_rtype ? decoded.rd : decoded.rt;
        case (opcode)
            OP_RTYPE: decoded.writes_reg = funct inside {FN_SLL, FN_SRL, FN_SRA, FN_ADDU,
                FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLTU};
            OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_SLTI, OP_SLTIU, OP_LW:
                decoded.writes_reg = 1'b1;
            default: decoded.writes_reg = 1'b0;
        endcase
    end

    always_comb begin
        case (opcode)
            OP_RTYPE: begin
                case (funct)
                    FN_ADDU: alu_result = rs_data + rt_data;
                    FN_SUBU: alu_result = rs_data - rt_data;
                    FN_AND:  alu_result = rs_data & rt_data;
                    FN_OR:   alu_result = rs_data | rt_data;
                    FN_XOR:  alu_result = rs_data ^ rt_data;
                    FN_SLT:  alu_result = {31'b0, $signed(rs_data) < $signed(rt_data)};
                    FN_SLTU: alu_result = {31'b0, rs_data < rt_data};
                    FN_SLL:  alu_result = rt_data << decoded.shamt;
                    FN_SRL:  alu_result = rt_data >> decoded.shamt;
                    FN_SRA:  alu_result = $signed(rt_data) >>> decoded.shamt;
                    default: alu_result = '0;
                endcase
            end
            OP_ADDIU: alu_result = rs_data + imm_sext;
            OP_ANDI:  alu_result = rs_data & imm_zext;
            OP_ORI:   alu_result = rs_data | imm_zext;
            OP_XORI:  alu_result = rs_data ^ imm_zext;
            OP_LUI:   alu_result = {instr[15:0], 16'h0000};
            OP_SLTI:  alu_result = {31'b0, $signed(rs_data) < $signed(imm_sext)};
            // Unsigned compare, but against the sign-extended immediate
            OP_SLTIU: alu_result = {31'b0, rs_data < imm_sext};
            default:  alu_result = '0;
        endcase
    end

    assign mem_addr = rs_data + imm_sext;

    always_comb begin
        if (decoded.is_jump || decoded.is_jump_reg) begin
            branch_taken = 1'b1;
        end else if (decoded.is_branch) begin
            // BNE takes the opposite outcome of BEQ
            branch_taken = (rs_data == rt_data) ^ (opcode == OP_BNE);
        end else begin
            branch_taken = 1'b0;
        end
    end

endmodule

/* logic/mips_cpu_bus.sv */
`timescale 1ns/1ps

module mips_cpu_bus
    import mips_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    cpu_state_t state;
    decoded_t   decoded;
    word_t      ir;
    word_t      pc;
    word_t      next_pc;
    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_result;
    word_t      mem_addr;
    word_t      wb_data;
    logic       branch_taken;
    logic       addr_sel;
    logic       ir_load;
    logic       pc_advance;
    logic       reg_write;

    mips_control u_control (
        .clk(clk), .reset(reset), .waitrequest(waitrequest),
        .decoded(decoded), .next_pc(next_pc), .state(state), .active(active),
        .read(read), .write(write), .addr_sel(addr_sel), .ir_load(ir_load),
        .pc_advance(pc_advance), .reg_write(reg_write)
    );

    mips_pc u_pc (
        .clk(clk), .reset(reset), .pc_advance(pc_advance), .decoded(decoded),
        .branch_taken(branch_taken), .jump_target_reg(rs_data),
        .pc(pc), .next_pc(next_pc)
    );

    mips_regfile u_regfile (
        .clk(clk), .reset(reset), .rs_idx(decoded.rs), .rt_idx(decoded.rt),
        .write_en(reg_write), .write_idx(decoded.dest), .write_data(wb_data),
        .rs_data(rs_data), .rt_data(rt_data), .v0(register_v0)
    );

    mips_alu u_alu (
        .instr(ir), .rs_data(rs_data), .rt_data(rt_data), .decoded(decoded),
        .alu_result(alu_result), .mem_addr(mem_addr), .branch_taken(branch_taken)
    );

    // Instruction captured on the accepted fetch
    always_ff @(posedge clk) begin
        if (ir_load) begin
            ir <= readdata;
        end
    end

    assign address    = addr_sel ? mem_addr : pc;
    assign writedata  = rt_data;
    assign byteenable = (read || write) ? 4'b1111 : 4'b0000;

    // Only a load writes back from the MEM state
    assign wb_data = (state == MEM) ? readdata : alu_result;

endmodule

/* sim/avalon_mem_model.sv */
`timescale 1ns/1ps

module avalon_mem_model (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    input  logic [3:0]  byteenable,
    output logic [31:0] readdata,
    output logic        waitrequest
);

    localparam int DEPTH       = 128;
    localparam int MAX_RECORDS = 128;

    logic [31:0] words [DEPTH];
    logic [31:0] patterns [3*MAX_RECORDS];
    logic [1:0]  stall_left;
    integer      seed;
    int          read_idx;

    // Low half is the data region at zero, high half the boot region
    function automatic int word_index(input logic [31:0] addr);
        if (addr[31:8] == 24'h000000) begin
            return int'(addr[7:2]);
        end else if (addr[31:8] == 24'hBFC000) begin
            return 64 + int'(addr[7:2]);
        end
        return -1;
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ 32'hA5A5_5A5A;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        int idx;
        idx = word_index(addr);
        if (idx >= 0) begin
            return words[idx];
        end
        return fill_word(addr);
    endfunction

    initial begin
        int idx;
        seed = 82;
        for (int i = 0; i < DEPTH; i++) begin
            if (i < 64) begin
                words[i] = fill_word(32'(i * 4));
            end else begin
                words[i] = fill_word(32'hBFC0_0000 + 32'((i - 64) * 4));
            end
        end
        $readmemh("sim/program_patterns.txt", patterns);
        // Only kind 0 records preload the memory
        for (int r = 0; r < MAX_RECORDS; r++) begin
            if (patterns[3*r] === 32'h0) begin
                idx = word_index(patterns[3*r+1]);
                if (idx >= 0) begin
                    words[idx] = patterns[3*r+2];
                end
            end
        end
        stall_left = 2'($random(seed));
    end

    assign read_idx    = word_index(address);
    assign waitrequest = (stall_left != 2'd0);
    assign readdata    = (read !== 1'b1) ? 32'h0 :
                         (read_idx >= 0) ? words[read_idx] : fill_word(address);

    always @(posedge clk) begin
        int idx;
        if (read === 1'b1 || write === 1'b1) begin
            if (stall_left != 2'd0) begin
                stall_left <= stall_left - 2'd1;
            end else begin
                idx = word_index(address);
                if (write === 1'b1 && idx >= 0) begin
                    for (int b = 0; b < 4; b++) begin
                        if (byteenable[b]) begin
                            words[idx][8*b +: 8] <= writedata[8*b +: 8];
                        end
                    end
                end
                // Stall length for the next transfer
                stall_left <= 2'($random(seed));
            end
        end
    end

endmodule

/* sim/mips_cpu_bus_tb.sv */
`timescale 1ns/1ps

module mips_cpu_bus_tb;

    localparam int MAX_RECORDS      = 128;
    localparam int CYCLES_PER_WORD  = 8 * 3;
    localparam int HALT_HOLD_CYCLES = 20;

    logic        clk;
    logic        reset;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic        waitrequest;
    logic [31:0] writedata;
    logic [3:0]  byteenable;
    logic [31:0] readdata;

    logic [31:0] patterns [3*MAX_RECORDS];
    int          error_count;
    int          check_count;
    int          program_words;
    int          cycle_limit;
    int          cycles;
    logic        first_fetch_seen;
    logic        prev_stalled;
    logic [31:0] prev_address;
    logic        prev_read;
    logic        prev_write;
    logic [31:0] prev_writedata;

    mips_cpu_bus uut (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    avalon_mem_model mem (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata),
        .waitrequest(waitrequest)
    );

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s is %h, expected %h", name, actual, expected);
        end
    endtask

    // Bus protocol watched in the middle of each cycle
    always @(negedge clk) begin
        if (reset) begin
            first_fetch_seen = 1'b0;
            prev_stalled     = 1'b0;
        end else begin
            if (!first_fetch_seen && read) begin
                check_value("first fetch address", address, 32'hBFC0_0000);
                first_fetch_seen = 1'b1;
            end
            if (read || write) begin
                check_value("byteenable", {28'h0, byteenable}, 32'hF);
                check_value("read & write", {31'h0, read & write}, 32'h0);
            end
            // Master must hold the request while stalled
            if (prev_stalled) begin
                check_value("address", address, prev_address);
                check_value("read", {31'h0, read}, {31'h0, prev_read});
                check_value("write", {31'h0, write}, {31'h0, prev_write});
                if (prev_write) begin
                    check_value("writedata", writedata, prev_writedata);
                end
            end
            prev_stalled   = (read || write) && waitrequest;
            prev_address   = address;
            prev_read      = read;
            prev_write     = write;
            prev_writedata = writedata;
        end
    end

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        error_count = 0;
        check_count = 0;
        $readmemh("sim/program_patterns.txt", patterns);
        program_words = 0;
        for (int r = 0; r < MAX_RECORDS; r++) begin
            if (patterns[3*r] === 32'h0 && patterns[3*r+1][31:28] == 4'hB) begin
                program_words++;
            end
        end
        cycle_limit = program_words * CYCLES_PER_WORD;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (active === 1'b1 && cycles < cycle_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (active !== 1'b0) begin
            error_count++;
            $display("Timeout: the processor never halted within %0d cycles", cycle_limit);
        end else begin
            repeat (HALT_HOLD_CYCLES) begin
                @(negedge clk);
                check_value("active", {31'h0, active}, 32'h0);
                check_value("read", {31'h0, read}, 32'h0);
                check_value("write", {31'h0, write}, 32'h0);
            end
            for (int r = 0; r < MAX_RECORDS; r++) begin
                if (patterns[3*r] === 32'h1) begin
                    check_value($sformatf("mem[%h]", patterns[3*r+1]),
                                mem.word_at(patterns[3*r+1]), patterns[3*r+2]);
                end else if (patterns[3*r] === 32'h2) begin
                    check_value("register_v0", register_v0, patterns[3*r+2]);
                end
            end
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sim/program_patterns.txt */
// kind address value, all hex
// kind 0 preloads a word, 1 is the expected memory word, 2 the expected register_v0
0 BFC00000 3C081234
0 BFC00004 35088765
0 BFC00008 2409FFFD
0 BFC0000C 01091021
0 BFC00010 01095023
0 BFC00014 010A5824
0 BFC00018 010A6026
0 BFC0001C 016C6825
0 BFC00020 004D1021
0 BFC00024 0128582A
0 BFC00028 0128602B
0 BFC0002C 292DFFFE
0 BFC00030 2D0EFFFF
0 BFC00034 00097902
0 BFC00038 0009C103
0 BFC0003C 01F87826
0 BFC00040 31388001
0 BFC00044 3B188000
0 BFC00048 0018C200
0 BFC0004C 016C5821
0 BFC00050 016D5821
0 BFC00054 016E5821
0 BFC00058 016F5821
0 BFC0005C 01785821
0 BFC00060 AC0B0044
0 BFC00064 AC020040
0 BFC00068 8C0C0040
0 BFC0006C 8C0D0048
0 BFC00070 018D1021
0 BFC00074 118C0002
0 BFC00078 24420011
0 BFC0007C 24420099
0 BFC00080 158C0002
0 BFC00084 24420022
0 BFC00088 24420033
0 BFC0008C 0BF00026
0 BFC00090 24420044
0 BFC00094 24420099
0 BFC00098 24000055
0 BFC0009C 00401021
0 BFC000A0 00000008
0 BFC000A4 AC020060
0 00000048 00C0FFEE
1 00000040 24690ECF
1 00000044 F0000103
1 00000048 00C0FFEE
1 00000060 252A0F67
2 00000000 252A0F67

/* vlog.f */
logic/mips_pkg.sv
logic/mips_control.sv
logic/mips_pc.sv
logic/mips_regfile.sv
logic/mips_alu.sv
logic/mips_cpu_bus.sv
sim/avalon_mem_model.sv
sim/mips_cpu_bus_tb.sv
